// ==== common/mem_stage_config.svh ====
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// ========================================
// Memory stage widths
// ========================================

// Data and address width
`define MEM_XLEN 32

// Width of each debug access counter
`define MEM_COUNT_WIDTH 32

`endif

// ==== common/mem_stage_pkg.sv ====
`include "mem_stage_config.svh"

package mem_stage_pkg;

	// Access width of a load or store
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_width_e;

	// ========================================
	// Execute to memory
	// ========================================

	typedef struct packed {
		logic strobe;
		logic [`MEM_XLEN-1:0] pc;
		// Result for pass-through, store data for stores
		logic [`MEM_XLEN-1:0] rd;
		logic [4:0] inst_rd;
		logic mem_read;
		logic mem_write;
		logic mem_signed;
		mem_width_e mem_width;
		logic [`MEM_XLEN-1:0] mem_address;
	} exec_op_t;

	typedef struct packed {
		logic strobe;
		logic [`MEM_XLEN-1:0] pc;
		logic [`MEM_XLEN-1:0] rd;
		logic [4:0] inst_rd;
	} mem_result_t;

	// ========================================
	// Data bus
	// ========================================

	typedef struct packed {
		logic request;
		logic rw;
		logic [`MEM_XLEN-1:0] address;
		logic [`MEM_XLEN-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [`MEM_XLEN-1:0] rdata;
	} bus_rsp_t;

	// One bus word seen as bytes or as halves
	typedef union packed {
		logic [3:0][7:0] bytes;
		logic [1:0][15:0] halves;
	} mem_word_u;

endpackage

// ==== mem_stage/access_counter.sv ====
`include "mem_stage_config.svh"

module access_counter (
	input logic i_clock,
	input logic i_rst,
	input logic i_load_done,
	input logic i_store_done,
	output logic [`MEM_COUNT_WIDTH-1:0] o_load_count,
	output logic [`MEM_COUNT_WIDTH-1:0] o_store_count
);

	// Debug counters wrap at full width
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_load_count <= '0;
			o_store_count <= '0;
		end else begin
			if (i_load_done) begin
				o_load_count <= o_load_count + 1'b1;
			end
			if (i_store_done) begin
				o_store_count <= o_store_count + 1'b1;
			end
		end
	end

endmodule

// ==== mem_stage/load_align.sv ====
`include "mem_stage_config.svh"

module load_align (
	input mem_stage_pkg::mem_word_u i_word,
	input logic [1:0] i_byte_index,
	input mem_stage_pkg::mem_width_e i_width,
	input logic i_signed,
	output logic [`MEM_XLEN-1:0] o_value
);
	import mem_stage_pkg::*;

	logic [7:0] sel_byte;
	logic [15:0] sel_half;

	assign sel_byte = i_word.bytes[i_byte_index];
	// Halves are only at index 0 or 2
	assign sel_half = i_word.halves[i_byte_index[1]];

	always_comb begin
		unique case (i_width)
			MEM_BYTE: begin
				o_value = {{(`MEM_XLEN-8){i_signed & sel_byte[7]}}, sel_byte};
			end
			MEM_HALF: begin
				o_value = {{(`MEM_XLEN-16){i_signed & sel_half[15]}}, sel_half};
			end
			default: begin
				o_value = i_word;
			end
		endcase
	end

endmodule

// ==== mem_stage/mem_stage_fsm.sv ====
`include "mem_stage_config.svh"

module mem_stage_fsm (
	input logic i_clock,
	input logic i_rst,
	input mem_stage_pkg::exec_op_t i_op,
	input mem_stage_pkg::bus_rsp_t i_bus,
	input logic [`MEM_XLEN-1:0] i_load_value,
	input logic [`MEM_XLEN-1:0] i_merged_word,
	output mem_stage_pkg::bus_req_t o_bus,
	output logic [`MEM_XLEN-1:0] o_read_word,
	output mem_stage_pkg::mem_result_t o_result,
	output logic o_busy,
	output logic o_load_done,
	output logic o_store_done
);
	import mem_stage_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE_WORD,
		ST_MERGE_READ,
		ST_MERGE_WRITE
	} state_e;

	state_e state;
	logic last_strobe;
	logic pending;
	logic is_word;
	logic pass_done;
	logic complete;

	logic bus_request;
	logic bus_rw;
	logic [`MEM_XLEN-1:0] bus_address;
	logic [`MEM_XLEN-1:0] bus_wdata;
	logic [`MEM_XLEN-1:0] rmw_word;

	logic result_strobe;
	logic [`MEM_XLEN-1:0] result_pc;
	logic [`MEM_XLEN-1:0] result_rd;
	logic [4:0] result_inst_rd;

	// ========================================
	// Operation decode
	// ========================================

	assign pending = i_op.strobe != last_strobe;
	assign is_word = i_op.mem_width == MEM_WORD;
	assign o_busy = pending && (i_op.mem_read || i_op.mem_write);

	// Completion happens at the edge that samples ready
	assign pass_done = (state == ST_IDLE) && pending && !i_op.mem_read && !i_op.mem_write;
	assign o_load_done = (state == ST_READ) && i_bus.ready;
	assign o_store_done = ((state == ST_WRITE_WORD) || (state == ST_MERGE_WRITE)) && i_bus.ready;
	assign complete = pass_done || o_load_done || o_store_done;

	// Live bus data for loads, captured word while merging
	assign o_read_word = (state == ST_MERGE_WRITE) ? rmw_word : i_bus.rdata;

	// ========================================
	// Control
	// ========================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			last_strobe <= 1'b0;
			result_strobe <= 1'b0;
			bus_request <= 1'b0;
			bus_rw <= 1'b0;
		end else begin
			if (complete) begin
				result_strobe <= ~result_strobe;
				last_strobe <= i_op.strobe;
			end

			unique case (state)
				ST_IDLE: begin
					if (o_busy) begin
						bus_request <= 1'b1;
						if (i_op.mem_read) begin
							bus_rw <= 1'b0;
							state <= ST_READ;
						end else if (is_word) begin
							bus_rw <= 1'b1;
							state <= ST_WRITE_WORD;
						end else begin
							// Sub-word store reads the word first
							bus_rw <= 1'b0;
							state <= ST_MERGE_READ;
						end
					end
				end
				ST_READ, ST_WRITE_WORD: begin
					if (i_bus.ready) begin
						bus_request <= 1'b0;
						bus_rw <= 1'b0;
						state <= ST_IDLE;
					end
				end
				ST_MERGE_READ: begin
					if (i_bus.ready) begin
						bus_request <= 1'b0;
						state <= ST_MERGE_WRITE;
					end
				end
				ST_MERGE_WRITE: begin
					if (i_bus.ready) begin
						bus_request <= 1'b0;
						bus_rw <= 1'b0;
						state <= ST_IDLE;
					end else begin
						// Request stays low for the merge cycle
						bus_request <= 1'b1;
						bus_rw <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ========================================
	// Bus and result data
	// ========================================

	always_ff @(posedge i_clock) begin
		if ((state == ST_IDLE) && o_busy) begin
			bus_address <= {i_op.mem_address[`MEM_XLEN-1:2], 2'b00};
			bus_wdata <= i_op.rd;
		end
		if ((state == ST_MERGE_READ) && i_bus.ready) begin
			rmw_word <= i_bus.rdata;
		end
		if (state == ST_MERGE_WRITE) begin
			bus_wdata <= i_merged_word;
		end
		if (complete) begin
			result_pc <= i_op.pc;
			result_rd <= (state == ST_READ) ? i_load_value : i_op.rd;
			result_inst_rd <= i_op.inst_rd;
		end
	end

	assign o_bus = '{
		request: bus_request,
		rw: bus_rw,
		address: bus_address,
		wdata: bus_wdata
	};

	assign o_result = '{
		strobe: result_strobe,
		pc: result_pc,
		rd: result_rd,
		inst_rd: result_inst_rd
	};

endmodule

// ==== mem_stage/store_merge.sv ====
`include "mem_stage_config.svh"

module store_merge (
	input mem_stage_pkg::mem_word_u i_old_word,
	input logic [`MEM_XLEN-1:0] i_store_data,
	input logic [1:0] i_byte_index,
	input mem_stage_pkg::mem_width_e i_width,
	output logic [`MEM_XLEN-1:0] o_new_word
);
	import mem_stage_pkg::*;

	mem_word_u new_word;

	// Untouched bytes come from the old word
	always_comb begin
		new_word = i_old_word;
		unique case (i_width)
			MEM_BYTE: begin
				new_word.bytes[i_byte_index] = i_store_data[7:0];
			end
			MEM_HALF: begin
				new_word.halves[i_byte_index[1]] = i_store_data[15:0];
			end
			default: begin
				new_word = i_store_data;
			end
		endcase
	end

	assign o_new_word = new_word;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_mem_stage -Mdir "$BUILD_DIR" -o tb_mem_stage -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BUILD_DIR/tb_mem_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
exit 0

// ==== source/mem_stage.sv ====
`include "mem_stage_config.svh"

module mem_stage (
	input logic i_clock,
	input logic i_rst,
	input mem_stage_pkg::exec_op_t i_op,
	output logic o_busy,
	output mem_stage_pkg::mem_result_t o_result,
	output mem_stage_pkg::bus_req_t o_bus,
	input mem_stage_pkg::bus_rsp_t i_bus,
	output logic [`MEM_COUNT_WIDTH-1:0] o_load_count,
	output logic [`MEM_COUNT_WIDTH-1:0] o_store_count
);

	logic [`MEM_XLEN-1:0] read_word;
	logic [`MEM_XLEN-1:0] load_value;
	logic [`MEM_XLEN-1:0] merged_word;
	logic load_done;
	logic store_done;

	// ========================================
	// Sequencing
	// ========================================

	mem_stage_fsm fsm_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_op(i_op),
		.i_bus(i_bus),
		.i_load_value(load_value),
		.i_merged_word(merged_word),
		.o_bus(o_bus),
		.o_read_word(read_word),
		.o_result(o_result),
		.o_busy(o_busy),
		.o_load_done(load_done),
		.o_store_done(store_done)
	);

	// ========================================
	// Data path
	// ========================================

	load_align load_align_i (
		.i_word(read_word),
		.i_byte_index(i_op.mem_address[1:0]),
		.i_width(i_op.mem_width),
		.i_signed(i_op.mem_signed),
		.o_value(load_value)
	);

	store_merge store_merge_i (
		.i_old_word(read_word),
		.i_store_data(i_op.rd),
		.i_byte_index(i_op.mem_address[1:0]),
		.i_width(i_op.mem_width),
		.o_new_word(merged_word)
	);

	// Debug counts
	access_counter access_counter_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_load_done(load_done),
		.i_store_done(store_done),
		.o_load_count(o_load_count),
		.o_store_count(o_store_count)
	);

endmodule

// ==== verif/tb_checker.sv ====
`include "mem_stage_config.svh"

module tb_checker (
	input logic i_clock,
	input logic i_rst,
	input mem_stage_pkg::exec_op_t i_op,
	input mem_stage_pkg::mem_result_t i_result,
	input logic i_busy,
	input mem_stage_pkg::bus_req_t i_bus,
	input mem_stage_pkg::bus_rsp_t i_bus_rsp,
	input logic [`MEM_COUNT_WIDTH-1:0] i_load_count,
	input logic [`MEM_COUNT_WIDTH-1:0] i_store_count,
	input logic [`MEM_XLEN-1:0] i_bus_mem [64],
	input logic i_final_check,
	output int o_mismatch_count,
	output int o_other_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import mem_stage_pkg::*;

	logic [`MEM_XLEN-1:0] shadow [64];
	logic [`MEM_COUNT_WIDTH-1:0] exp_loads;
	logic [`MEM_COUNT_WIDTH-1:0] exp_stores;
	logic last_strobe = 1'b0;
	logic exp_busy;
	logic reset_seen = 1'b0;
	logic reset_checked = 1'b0;
	logic held = 1'b0;
	logic ready_prev = 1'b0;
	bus_req_t prev_bus;
	int mismatches = 0;
	int others = 0;

	assign o_mismatch_count = mismatches;
	assign o_other_count = others;

	task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			mismatches++;
			$display("MISMATCH %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report(string what);
		others++;
		$display("ERROR: %s", what);
	endtask

	// Upper bits filled with the sign or with zero
	function automatic logic [31:0] extend(logic [31:0] value, int bits, logic sign);
		logic [31:0] mask;
		mask = (32'h1 << bits) - 32'h1;
		if (sign && value[bits-1]) begin
			return value | ~mask;
		end else begin
			return value & mask;
		end
	endfunction

	task automatic check_completion();
		logic [5:0] idx;
		logic [4:0] shift;
		logic [31:0] mask;
		logic [31:0] exp_rd;
		int bits;
		string name;
		idx = i_op.mem_address[7:2];
		shift = {i_op.mem_address[1:0], 3'b000};
		exp_rd = i_op.rd;
		case (i_op.mem_width)
			MEM_BYTE: bits = 8;
			MEM_HALF: bits = 16;
			default: bits = 32;
		endcase
		name = $sformatf("%0d-bit", bits);
		if (i_op.mem_read) begin
			if (i_op.mem_signed) begin
				name = {"load ", name, " signed"};
			end else begin
				name = {"load ", name, " unsigned"};
			end
			exp_rd = extend(shadow[idx] >> shift, bits, i_op.mem_signed);
			exp_loads = exp_loads + 32'd1;
		end else if (i_op.mem_write) begin
			name = {"store ", name};
			mask = ((32'h1 << bits) - 32'h1) << shift;
			shadow[idx] = (shadow[idx] & ~mask) | ((i_op.rd << shift) & mask);
			exp_stores = exp_stores + 32'd1;
		end else begin
			name = "pass-through";
		end
		compare({name, " pc"}, i_op.pc, i_result.pc);
		compare({name, " rd"}, exp_rd, i_result.rd);
		compare({name, " inst_rd"}, {27'b0, i_op.inst_rd}, {27'b0, i_result.inst_rd});
		compare({name, " load count"}, exp_loads, i_load_count);
		compare({name, " store count"}, exp_stores, i_store_count);
	endtask

	// ========================================
	// Sampling at each rising edge
	// ========================================

	always @(posedge i_clock) begin
		if (i_rst) begin
			shadow = i_bus_mem;
			exp_loads = '0;
			exp_stores = '0;
			last_strobe = 1'b0;
			held = 1'b0;
			ready_prev = 1'b0;
			reset_seen = 1'b1;
		end else begin
			if (reset_seen && !reset_checked) begin
				reset_checked = 1'b1;
				if (i_bus.request || i_result.strobe || i_load_count != '0
						|| i_store_count != '0) begin
					report("request, result strobe or counters not cleared by reset");
				end
			end
			if (held && i_bus != prev_bus) begin
				report("bus request fields changed while waiting for ready");
			end
			if (ready_prev && i_bus.request) begin
				report("bus request still high in the cycle after ready");
			end
			if (i_bus.request && i_bus.address[1:0] != 2'b00) begin
				report($sformatf("bus address %h is not word aligned", i_bus.address));
			end
			held = i_bus.request && !i_bus_rsp.ready;
			ready_prev = i_bus_rsp.ready;
			prev_bus = i_bus;
			if (i_result.strobe != last_strobe) begin
				last_strobe = i_result.strobe;
				check_completion();
			end
			// Busy while a load or store waits for its result
			exp_busy = (i_op.strobe != last_strobe) && (i_op.mem_read || i_op.mem_write);
			compare("busy", {31'b0, exp_busy}, {31'b0, i_busy});
			if (i_final_check) begin
				for (int i = 0; i < 64; i++) begin
					compare($sformatf("final memory word %0d", i), shadow[i], i_bus_mem[i]);
				end
			end
		end
	end

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic o_clock,
	output logic o_rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// Reset covers the first three rising edges
	initial begin
		o_clock = 1'b0;
		o_rst <= 1'b1;
		repeat (3) @(posedge o_clock);
		o_rst <= 1'b0;
	end

	always #5 o_clock = ~o_clock;

endmodule

// ==== verif/tb_mem_stage.sv ====
`include "mem_stage_config.svh"

module tb_mem_stage;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_stage_pkg::*;

	localparam int OP_COUNT = 400;
	// Worst operation takes about 14 cycles so allow 20 each
	localparam int TIMEOUT_CYCLES = OP_COUNT * 20;
	localparam int MEM_WORDS = 64;
	localparam int DELAY_SLOTS = 512;

	logic clock;
	logic rst;
	exec_op_t op = '0;
	bus_rsp_t bus_rsp = '0;
	logic final_check = 1'b0;
	mem_result_t dut_result;
	bus_req_t dut_bus;
	logic dut_busy;
	logic [`MEM_COUNT_WIDTH-1:0] load_count;
	logic [`MEM_COUNT_WIDTH-1:0] store_count;
	int mismatch_count;
	int other_count;

	logic [`MEM_XLEN-1:0] bus_mem [MEM_WORDS];
	int delay_table [DELAY_SLOTS];
	int seed;
	int txn_count = 0;
	int wait_left = -1;
	int ops_issued = 0;
	int cycles = 0;

	tb_clock_gen clock_gen_i (
		.o_clock(clock),
		.o_rst(rst)
	);

	mem_stage dut_i (
		.i_clock(clock),
		.i_rst(rst),
		.i_op(op),
		.o_busy(dut_busy),
		.o_result(dut_result),
		.o_bus(dut_bus),
		.i_bus(bus_rsp),
		.o_load_count(load_count),
		.o_store_count(store_count)
	);

	tb_checker checker_i (
		.i_clock(clock),
		.i_rst(rst),
		.i_op(op),
		.i_result(dut_result),
		.i_busy(dut_busy),
		.i_bus(dut_bus),
		.i_bus_rsp(bus_rsp),
		.i_load_count(load_count),
		.i_store_count(store_count),
		.i_bus_mem(bus_mem),
		.i_final_check(final_check),
		.o_mismatch_count(mismatch_count),
		.o_other_count(other_count)
	);

	// Start content mixed from the full word address
	function automatic logic [`MEM_XLEN-1:0] fill_word(logic [5:0] index);
		logic [`MEM_XLEN-1:0] addr;
		addr = {24'h000010, index, 2'b00};
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
	endfunction

	task automatic build_op(input logic strobe, output exec_op_t new_op);
		int kind;
		int width_pick;
		logic [5:0] word_index;
		logic [1:0] offset;
		new_op = '0;
		new_op.strobe = strobe;
		new_op.pc = $random(seed);
		new_op.pc[1:0] = 2'b00;
		new_op.rd = $random(seed);
		new_op.inst_rd = 5'($random(seed));
		new_op.mem_signed = 1'($random(seed));
		kind = $unsigned($random(seed)) % 3;
		width_pick = $unsigned($random(seed)) % 3;
		word_index = 6'($random(seed));
		offset = 2'($random(seed));
		case (width_pick)
			0: new_op.mem_width = MEM_BYTE;
			1: begin
				new_op.mem_width = MEM_HALF;
				offset[0] = 1'b0;
			end
			default: begin
				new_op.mem_width = MEM_WORD;
				offset = 2'b00;
			end
		endcase
		new_op.mem_read = (kind == 1);
		new_op.mem_write = (kind == 2);
		new_op.mem_address = {24'h000010, word_index, offset};
	endtask

	// ========================================
	// Bus memory with one-cycle ready
	// ========================================

	always @(posedge clock) begin
		if (rst) begin
			bus_rsp <= '0;
			wait_left = -1;
			for (int i = 0; i < MEM_WORDS; i++) begin
				bus_mem[i] <= fill_word(i[5:0]);
			end
		end else if (bus_rsp.ready) begin
			bus_rsp.ready <= 1'b0;
		end else if (dut_bus.request) begin
			if (wait_left < 0) begin
				wait_left = delay_table[txn_count % DELAY_SLOTS];
				txn_count++;
			end
			if (wait_left == 0) begin
				bus_rsp.ready <= 1'b1;
				bus_rsp.rdata <= bus_mem[dut_bus.address[7:2]];
				if (dut_bus.rw) begin
					bus_mem[dut_bus.address[7:2]] <= dut_bus.wdata;
				end
			end
			wait_left--;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("ERROR: timeout after %0d cycles, %0d of %0d operations issued",
				TIMEOUT_CYCLES, ops_issued, OP_COUNT);
			$display("Closing counts: %0d mismatches, %0d other errors",
				mismatch_count, other_count + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	initial begin
		logic start_strobe;
		exec_op_t new_op;
		seed = 32'hef69;
		for (int i = 0; i < DELAY_SLOTS; i++) begin
			delay_table[i] = $unsigned($random(seed)) % 4;
		end
		@(posedge clock);
		while (rst) begin
			@(posedge clock);
		end
		for (int n = 0; n < OP_COUNT; n++) begin
			build_op(~op.strobe, new_op);
			op <= new_op;
			ops_issued++;
			start_strobe = dut_result.strobe;
			@(posedge clock);
			while (dut_result.strobe == start_strobe) begin
				@(posedge clock);
			end
		end
		final_check <= 1'b1;
		@(posedge clock);
		final_check <= 1'b0;
		@(posedge clock);
		$display("Closing counts: %0d mismatches, %0d other errors",
			mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+common
common/mem_stage_pkg.sv
mem_stage/load_align.sv
mem_stage/store_merge.sv
mem_stage/access_counter.sv
mem_stage/mem_stage_fsm.sv
source/mem_stage.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_mem_stage.sv
